// File: dv/icmu_tb.sv
// Inputs change on falling edges; pending lines are raised only while the DUT is idle, one dispatch at a time.
`include "icmu_settings.svh"

module icmu_tb;

    localparam int CYCLE_LIMIT   = 20000;   // About 40 cycles per random round plus the directed tests.
    localparam int RANDOM_ROUNDS = 300;
    localparam int QUIET_CYCLES  = 6;

    logic                       clk;
    logic                       rst_sync;
    icmu_pkg::ctx_wr_t          ctx_wr;
    logic [`ICMU_IDX_W-1:0]     rd_index;
    logic [`ICMU_DW-1:0]        rd_data;
    logic                       active_bank;
    logic [`ICMU_IRQ_COUNT-1:0] irq_pending;
    logic                       dispatch_req;
    icmu_pkg::dispatch_t        dispatch;
    logic                       dispatch_ack;
    logic                       busy;

    logic [`ICMU_DW-1:0]        model_bank [2][`ICMU_DEPTH];
    logic                       model_sel;       // Active bank in the model.
    logic [`ICMU_IRQ_COUNT-1:0] model_pending;

    logic [31:0] rng_state = 32'h354d_0a5a;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          dispatch_seen = 0;

    icmu_top dut (
        .clk          (clk),
        .rst_sync     (rst_sync),
        .ctx_wr       (ctx_wr),
        .rd_index     (rd_index),
        .rd_data      (rd_data),
        .active_bank  (active_bank),
        .irq_pending  (irq_pending),
        .dispatch_req (dispatch_req),
        .dispatch     (dispatch),
        .dispatch_ack (dispatch_ack),
        .busy         (busy)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge dispatch_req) begin
        dispatch_seen = dispatch_seen + 1;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 15);   // Folds the better upper bits down.
    endfunction

    // The header word keeps the handler address in bits 31:8 and the block mask in bits 7:0.
    function automatic logic [`ICMU_IRQ_COUNT-1:0] model_eligible();
        return model_pending & ~model_bank[model_sel][0][`ICMU_IRQ_COUNT-1:0];
    endfunction

    function automatic int lowest_index(input logic [`ICMU_IRQ_COUNT-1:0] lines);
        int found;
        found = -1;
        for (int i = 0; i < `ICMU_IRQ_COUNT; i++) begin
            if (lines[i] && found < 0) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("[FAIL] time %0t %s expected 0x%h actual 0x%h",
                     $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic write_word(input logic [`ICMU_IDX_W-1:0] index, input logic [31:0] data);
        ctx_wr.valid    = 1'b1;
        ctx_wr.index    = index;
        ctx_wr.data.raw = data;
        model_bank[~model_sel][index] = data;   // The host always writes the shadow bank.
        @(negedge clk);
        ctx_wr.valid = 1'b0;
    endtask

    task automatic check_readback();
        for (int i = 0; i < `ICMU_DEPTH; i++) begin
            rd_index = `ICMU_IDX_W'(i);
            @(negedge clk);
            check_value($sformatf("rd_data[%0d]", i), rd_data, model_bank[model_sel][i]);
        end
        check_value("active_bank", 32'(active_bank), 32'(model_sel));
    endtask

    task automatic raise_lines(input logic [`ICMU_IRQ_COUNT-1:0] lines);
        irq_pending   = irq_pending | lines;
        model_pending = model_pending | lines;
        @(negedge clk);
    endtask

    // Processor side of one dispatch, with the expected result taken from the model.
    task automatic serve_dispatch();
        int          exp_id;
        int          delay;
        logic [31:0] exp_header;
        logic [31:0] r;
        exp_id     = lowest_index(model_eligible());
        model_sel  = ~model_sel;   // The winner brings the shadow context in.
        exp_header = model_bank[model_sel][0];
        while (!dispatch_req) begin
            @(negedge clk);
        end
        check_value("dispatch.irq_id", 32'(dispatch.irq_id), exp_id);
        check_value("dispatch.handler_addr", 32'(dispatch.handler_addr),
                    {8'h00, exp_header[31:8]});
        check_value("active_bank", 32'(active_bank), 32'(model_sel));
        check_value("busy", 32'(busy), 32'd1);
        r     = next_random();
        delay = int'(r[1:0]);
        repeat (delay) begin
            @(negedge clk);
        end
        dispatch_ack                 = 1'b1;
        irq_pending[dispatch.irq_id] = 1'b0;   // Served line is cleared along with the ack.
        model_pending[exp_id]        = 1'b0;
        while (dispatch_req) begin
            @(negedge clk);
        end
        dispatch_ack = 1'b0;
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic run_dispatches(output int served);
        int first_seen;
        first_seen = dispatch_seen;
        while (model_eligible() != '0) begin
            serve_dispatch();
        end
        // Nothing eligible is left, so the DUT has to stay quiet.
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("dispatch_req", 32'(dispatch_req), 32'd0);
            check_value("busy", 32'(busy), 32'd0);
        end
        served = dispatch_seen - first_seen;   // Dispatches the DUT actually raised.
    endtask

    initial begin
        int          served;
        int          total;
        logic [31:0] r;
        logic [31:0] m;
        clk          = 1'b0;
        rst_sync     = 1'b1;
        ctx_wr       = '0;
        rd_index     = '0;
        irq_pending  = '0;
        dispatch_ack = 1'b0;
        model_sel     = 1'b0;
        model_pending = '0;
        for (int b = 0; b < 2; b++) begin
            for (int w = 0; w < `ICMU_DEPTH; w++) begin
                model_bank[b][w] = '0;
            end
        end
        repeat (16) begin
            @(negedge clk);
        end
        rst_sync = 1'b0;

        check_value("dispatch_req", 32'(dispatch_req), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_readback();
        finish_test("reset state");

        write_word(3'd0, {24'h00_1000, 8'h00});
        for (int w = 1; w < `ICMU_DEPTH; w++) begin
            write_word(`ICMU_IDX_W'(w), next_random());
        end
        check_readback();   // Still the cleared active bank.
        finish_test("shadow writes");

        raise_lines(8'b1011_0100);
        run_dispatches(served);
        check_value("dispatch count", served, 32'd4);
        check_readback();
        finish_test("priority order");

        write_word(3'd0, {24'h24_68ac, 8'h00});
        for (int w = 1; w < 4; w++) begin
            write_word(`ICMU_IDX_W'(w), next_random());
        end
        raise_lines(8'b0100_0000);
        run_dispatches(served);
        check_value("dispatch count", served, 32'd1);
        check_readback();
        raise_lines(8'b0000_0010);   // Swap back to the context that was active before.
        run_dispatches(served);
        check_value("dispatch count", served, 32'd1);
        check_readback();
        finish_test("bank swap");

        write_word(3'd0, {24'h00_5a00, 8'h06});
        raise_lines(8'b0000_0001);
        run_dispatches(served);
        check_value("dispatch count", served, 32'd1);
        write_word(3'd0, {24'h00_7700, 8'h00});
        raise_lines(8'b0000_0110);
        run_dispatches(served);
        check_value("dispatch count", served, 32'd0);
        raise_lines(8'b0000_1000);
        run_dispatches(served);
        check_value("dispatch count", served, 32'd2);   // Line 2 is blocked again afterwards.
        raise_lines(8'b0001_0000);
        run_dispatches(served);
        check_value("dispatch count", served, 32'd2);
        check_value("irq_pending", 32'(irq_pending), 32'd0);
        finish_test("block mask");

        total = 0;
        for (int round = 0; round < RANDOM_ROUNDS; round++) begin
            r = next_random();
            m = next_random();
            write_word(3'd0, {r[31:8], r[7:0] & m[7:0]});
            for (int k = 0; k < int'(m[9:8]); k++) begin
                r = next_random();
                write_word(r[30:28], next_random());
            end
            r = next_random();
            m = next_random();
            raise_lines(r[7:0] & m[7:0]);
            run_dispatches(served);
            total += served;
            check_readback();
        end
        $display("random rounds served %0d dispatches", total);
        finish_test("random rounds");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Compiles the ICMU testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module icmu_tb

status=0
./obj_dir/Vicmu_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status."
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure, see sim.log."
    exit 1
fi

echo "Simulation finished without failures."

// File: tb.f
+incdir+verilog
verilog/icmu_pkg.sv
verilog/context_double_buffer.sv
verilog/irq_priority_arbiter.sv
verilog/context_switch_ctrl.sv
verilog/icmu_top.sv
dv/icmu_tb.sv

// File: verilog/context_double_buffer.sv
// Writes always go to the shadow bank; a write in the same cycle as a swap lands in the new active bank.
`include "icmu_settings.svh"

module context_double_buffer (
    input  logic                   clk,
    input  logic                   rst_sync,
    input  icmu_pkg::ctx_wr_t      wr,
    input  logic                   swap,
    input  logic [`ICMU_IDX_W-1:0] rd_index,
    output logic [`ICMU_DW-1:0]    rd_data,
    output icmu_pkg::ctx_header_t  active_header,
    output logic                   active_bank
);

    icmu_pkg::ctx_word_u bank [2][`ICMU_DEPTH];
    logic                sel;   // Index of the active bank.

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            sel <= 1'b0;
        end else if (swap) begin
            sel <= ~sel;   // The shadow bank becomes active.
        end
    end

    // Both banks start cleared, so the first active header blocks nothing.
    always_ff @(posedge clk) begin
        if (rst_sync) begin
            for (int b = 0; b < 2; b++) begin
                for (int w = 0; w < `ICMU_DEPTH; w++) begin
                    bank[b][w] <= '0;
                end
            end
        end else if (wr.valid) begin
            bank[~sel][wr.index] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            rd_data <= '0;
        end else begin
            rd_data <= bank[sel][rd_index].raw;   // One cycle read latency.
        end
    end

    // Header view of word 0, valid as soon as the bank select changes.
    assign active_header = bank[sel][0].header;
    assign active_bank   = sel;

endmodule

// File: verilog/context_switch_ctrl.sv
// One interrupt in flight at a time; dispatch_req rises two cycles after swap so the new header is used.
`include "icmu_settings.svh"

module context_switch_ctrl (
    input  logic                      clk,
    input  logic                      rst_sync,
    input  logic                      arb_req,
    input  logic [`ICMU_IRQ_ID_W-1:0] arb_id,
    input  icmu_pkg::ctx_header_t     active_header,
    output logic                      arb_ack,
    output logic                      swap,
    output logic                      dispatch_req,
    output icmu_pkg::dispatch_t       dispatch,
    input  logic                      dispatch_ack,
    output logic                      busy
);

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_SWAP     = 3'd1;
    localparam logic [2:0] ST_DISPATCH = 3'd2;
    localparam logic [2:0] ST_ACK_LOW  = 3'd3;
    localparam logic [2:0] ST_RELEASE  = 3'd4;
    localparam logic [2:0] ST_REQ_LOW  = 3'd5;

    logic [2:0] state;
    logic       latch_dispatch;

    // First cycle of ST_DISPATCH, the bank has already toggled.
    assign latch_dispatch = (state == ST_DISPATCH) && !dispatch_req;

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            state        <= ST_IDLE;
            swap         <= 1'b0;
            busy         <= 1'b0;
            dispatch_req <= 1'b0;
            arb_ack      <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (arb_req) begin
                        swap  <= 1'b1;
                        busy  <= 1'b1;   // Host must stop writing the shadow bank.
                        state <= ST_SWAP;
                    end
                end
                ST_SWAP: begin
                    swap  <= 1'b0;   // One-cycle pulse.
                    state <= ST_DISPATCH;
                end
                ST_DISPATCH: begin
                    if (latch_dispatch) begin
                        dispatch_req <= 1'b1;
                    end else if (dispatch_ack) begin
                        dispatch_req <= 1'b0;
                        state        <= ST_ACK_LOW;
                    end
                end
                ST_ACK_LOW: begin
                    if (!dispatch_ack) begin
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    arb_ack <= 1'b1;   // Dispatch is complete, let the arbiter go.
                    state   <= ST_REQ_LOW;
                end
                ST_REQ_LOW: begin
                    if (!arb_req) begin
                        arb_ack <= 1'b0;
                        busy    <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // The winner from the arbiter joined with the handler of the context now active.
    always_ff @(posedge clk) begin
        if (latch_dispatch) begin
            dispatch.irq_id       <= arb_id;
            dispatch.handler_addr <= active_header.handler_addr;
        end
    end

endmodule

// File: verilog/icmu_pkg.sv
// Word 0 of a context bank is the header; the other words carry no decoded meaning here.
`include "icmu_settings.svh"

package icmu_pkg;

    // Handler address sits in the upper 24 bits, block mask in the low byte.
    typedef struct packed {
        logic [`ICMU_ADDR_W-1:0] handler_addr;
        logic [`ICMU_MASK_W-1:0] block_mask;   // A set bit blocks the line of that index.
    } ctx_header_t;

    // One context word, seen either as raw data or as a header.
    typedef union packed {
        logic [`ICMU_DW-1:0] raw;
        ctx_header_t         header;
    } ctx_word_u;

    // Host write into the shadow bank.
    typedef struct packed {
        logic                   valid;
        logic [`ICMU_IDX_W-1:0] index;
        ctx_word_u              data;
    } ctx_wr_t;

    // What the processor receives for one taken interrupt.
    typedef struct packed {
        logic [`ICMU_IRQ_ID_W-1:0] irq_id;
        logic [`ICMU_ADDR_W-1:0]   handler_addr;
    } dispatch_t;

endpackage

// File: verilog/icmu_settings.svh
// Widths are fixed by the 32-bit context header layout; ICMU_IRQ_COUNT must not exceed 8.
`ifndef ICMU_SETTINGS_SVH
`define ICMU_SETTINGS_SVH

// Context word width. The header layout only fits 32.
`define ICMU_DW 32

// Words per context bank and the matching index width.
`define ICMU_DEPTH 8
`define ICMU_IDX_W 3

// Interrupt lines, one per block mask bit at most.
`define ICMU_IRQ_COUNT 8
`define ICMU_IRQ_ID_W 3

// Handler address and block mask fields of the header word.
`define ICMU_ADDR_W 24
`define ICMU_MASK_W 8

`endif

// File: verilog/icmu_top.sv
// Host writes are only safe while busy is low; the processor must clear the served line before dispatch_ack.
`include "icmu_settings.svh"

module icmu_top (
    input  logic                       clk,
    input  logic                       rst_sync,
    input  icmu_pkg::ctx_wr_t          ctx_wr,
    input  logic [`ICMU_IDX_W-1:0]     rd_index,
    output logic [`ICMU_DW-1:0]        rd_data,
    output logic                       active_bank,
    input  logic [`ICMU_IRQ_COUNT-1:0] irq_pending,
    output logic                       dispatch_req,
    output icmu_pkg::dispatch_t        dispatch,
    input  logic                       dispatch_ack,
    output logic                       busy
);

    icmu_pkg::ctx_header_t     active_header;
    logic                      swap;
    logic                      arb_req;
    logic                      arb_ack;
    logic [`ICMU_IRQ_ID_W-1:0] arb_id;

    context_double_buffer u_buffer (
        .clk           (clk),
        .rst_sync      (rst_sync),
        .wr            (ctx_wr),
        .swap          (swap),
        .rd_index      (rd_index),
        .rd_data       (rd_data),
        .active_header (active_header),
        .active_bank   (active_bank)
    );

    // Mask comes from the context active before the switch.
    irq_priority_arbiter u_arbiter (
        .clk           (clk),
        .rst_sync      (rst_sync),
        .irq_pending   (irq_pending),
        .active_header (active_header),
        .arb_ack       (arb_ack),
        .arb_req       (arb_req),
        .arb_id        (arb_id)
    );

    context_switch_ctrl u_ctrl (
        .clk           (clk),
        .rst_sync      (rst_sync),
        .arb_req       (arb_req),
        .arb_id        (arb_id),
        .active_header (active_header),
        .arb_ack       (arb_ack),
        .swap          (swap),
        .dispatch_req  (dispatch_req),
        .dispatch      (dispatch),
        .dispatch_ack  (dispatch_ack),
        .busy          (busy)
    );

endmodule

// File: verilog/irq_priority_arbiter.sv
// Fixed priority, lowest line index wins; pending lines must be held by the source until served.
`include "icmu_settings.svh"

module irq_priority_arbiter (
    input  logic                       clk,
    input  logic                       rst_sync,
    input  logic [`ICMU_IRQ_COUNT-1:0] irq_pending,
    input  icmu_pkg::ctx_header_t      active_header,
    input  logic                       arb_ack,
    output logic                       arb_req,
    output logic [`ICMU_IRQ_ID_W-1:0]  arb_id
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_REQ      = 2'd1;
    localparam logic [1:0] ST_ACK_WAIT = 2'd2;

    logic [1:0]                 state;
    logic [`ICMU_IRQ_COUNT-1:0] eligible;
    logic [`ICMU_IRQ_ID_W-1:0]  win_id;

    assign eligible = irq_pending & ~active_header.block_mask[`ICMU_IRQ_COUNT-1:0];

    // Scan from the top so the lowest set index is the one left standing.
    always_comb begin
        win_id = '0;
        for (int i = `ICMU_IRQ_COUNT - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                win_id = `ICMU_IRQ_ID_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            state   <= ST_IDLE;
            arb_req <= 1'b0;
            arb_id  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (|eligible && !arb_ack) begin
                        arb_req <= 1'b1;
                        arb_id  <= win_id;   // Held until the controller acknowledges.
                        state   <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (arb_ack) begin
                        arb_req <= 1'b0;
                        state   <= ST_ACK_WAIT;
                    end
                end
                ST_ACK_WAIT: begin
                    if (!arb_ack) begin
                        state <= ST_IDLE;   // Handshake closed, free to arbitrate again.
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule
